// ==== compile.f ====
+incdir+rtl
rtl/ks10Pkg.sv
rtl/apr.sv
rtl/piController.sv
rtl/aprPiTop.sv
dv/aprPiTb.sv

// ==== dv/aprPiTb.sv ====
////////////////////////////////////////////////////////////
// Directed checks of the APR device and the PI controller
// Model tracks writes only while clken is high
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "ks10_consts.svh"

module aprPiTb;

   import ks10Pkg::*;

   localparam int MaxCycles = 2000;

   logic      clk;
   logic      rst;
   logic      clken;
   cromWordT  crom;
   dataWordT  dp;
   extIntrT   extIntr;
   piLevelsT  extPiReq;
   aprFlagsT  aprFlags;
   piStatusT  piStatus;
   piNumT     piReqNum;
   logic      piReq;

   int          errors;
   int          cycles;
   int          seed;
   logic [31:0] rnd;
   logic [31:0] rnd2;
   piStatusT    pis;
   piNumT       heldNum;

   // Reference model state
   aprByteT  mFlags;
   aprByteT  mEna;
   logic     mTrap;
   logic     mPage;
   logic     mSw;
   piNumT    mLvl;
   piStatusT mPi;

   aprPiTop UUT
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .extIntr  (extIntr),
      .extPiReq (extPiReq),
      .aprFlags (aprFlags),
      .piStatus (piStatus),
      .piReqNum (piReqNum),
      .piReq    (piReq)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Run limit, tests take about 200 cycles
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MaxCycles)
      begin
         $display("Timeout: run did not finish within %0d cycles", MaxCycles);
         $display("Verification failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   // Rising edge, then 1 ns hold
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // One-cycle special-function strobe with its data word
   task automatic specWrite(input logic [4:0] code, input dataWordT data);
      crom = '0;
      crom[`CROM_SPEC_EN] = 1'b1;
      crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO] = code;
      dp = data;
      tick();
      crom = '0;
      dp = '0;
   endtask

   task automatic writeFlags(input aprByteT data, input extIntrT ext);
      dataWordT d;
      d = '0;
      d[24:31] = data;
      extIntr = ext;
      specWrite(`SPEC_APRFLAGS, d);
      extIntr = '0;
      if (clken)
      begin
         // Set-dominant hardware bits 26, 27, 31
         mFlags = data;
         mFlags[26] = data[26] | ext.pwr;
         mFlags[27] = data[27] | ext.nxm;
         mFlags[31] = data[31] | ext.cons;
      end
   endtask

   task automatic loadApr(input logic trap, input logic page, input aprByteT ena,
                          input logic sw, input piNumT lvl);
      dataWordT d;
      d = '0;
      d[22] = trap;
      d[23] = page;
      d[24:31] = ena;
      d[32] = sw;
      d[33:35] = lvl;
      specWrite(`SPEC_LOADAPR, d);
      if (clken)
      begin
         mTrap = trap;
         mPage = page;
         mEna = ena;
         mSw = sw;
         mLvl = lvl;
      end
   endtask

   task automatic loadPi(input piStatusT st);
      dataWordT d;
      d = '0;
      d[`DP_PI_SWREQ_HI:`DP_PI_SWREQ_LO] = st.swReq;
      d[`DP_PI_INPROG_HI:`DP_PI_INPROG_LO] = st.inProg;
      d[`DP_PI_ON] = st.piOn;
      d[`DP_PI_ENA_HI:`DP_PI_ENA_LO] = st.ena;
      specWrite(`SPEC_LOADPI, d);
      if (clken)
      begin
         mPi = st;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic aprFlagsT expectedFlags();
      aprFlagsT f;
      f.trapEn = mTrap;
      f.pageEn = mPage;
      {f.soft24, f.console25, f.pwr, f.nxm, f.badMem, f.corMem, f.timer, f.cons} = mFlags;
      // Software bit, or any flag that is both set and enabled
      f.intReq = mSw;
      for (int b = 24; b <= 31; b++)
      begin
         if (mFlags[b] && mEna[b])
         begin
            f.intReq = 1'b1;
         end
      end
      f.ones = 3'b111;
      return f;
   endfunction

   // APR request as seen by the PI merge
   function automatic piLevelsT expectedAprIntr();
      piLevelsT h;
      aprFlagsT f;
      h = '0;
      f = expectedFlags();
      if (f.intReq && (mLvl != 0))
      begin
         h[mLvl] = 1'b1;
      end
      return h;
   endfunction

   // Lowest-numbered request strictly above the highest level in progress
   function automatic piNumT expectedWinner(input piLevelsT ext);
      piLevelsT reqs;
      int       limit;
      piNumT    w;
      reqs = (mPi.swReq | expectedAprIntr() | ext) & mPi.ena;
      if (!mPi.piOn)
      begin
         reqs = '0;
      end
      limit = 8;
      for (int l = 7; l >= 1; l--)
      begin
         if (mPi.inProg[l])
         begin
            limit = l;
         end
      end
      w = '0;
      for (int l = 7; l >= 1; l--)
      begin
         if (reqs[l] && (l < limit))
         begin
            w = piNumT'(l);
         end
      end
      return w;
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic checkFlags(input aprFlagsT exp);
      if (aprFlags !== exp)
      begin
         $display("ERR aprFlags exp %h act %h", exp, aprFlags);
         errors++;
      end
   endtask

   task automatic checkStatus(input piStatusT exp);
      if (piStatus !== exp)
      begin
         $display("ERR piStatus exp %h act %h", exp, piStatus);
         errors++;
      end
   endtask

   // piReq must follow the number
   task automatic checkNum(input piNumT exp);
      if (piReqNum !== exp)
      begin
         $display("ERR piReqNum exp %h act %h", exp, piReqNum);
         errors++;
      end
      if (piReq !== (exp != 0))
      begin
         $display("ERR piReq exp %h act %h", (exp != 0), piReq);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   initial
   begin
      errors = 0;
      cycles = 0;
      seed = 3978;
      rst = 1'b1;
      clken = 1'b1;
      crom = '0;
      dp = '0;
      extIntr = '0;
      extPiReq = '0;
      mFlags = '0;
      mEna = '0;
      mTrap = 1'b0;
      mPage = 1'b0;
      mSw = 1'b0;
      mLvl = '0;
      mPi = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset values
      tick();
      checkFlags(expectedFlags());
      checkStatus('0);
      checkNum('0);

      // Random flag writes and enable loads
      for (int n = 0; n < 20; n++)
      begin
         rnd = $random(seed);
         loadApr(rnd[0], rnd[1], rnd[9:2], rnd[10], rnd[13:11]);
         checkFlags(expectedFlags());
         writeFlags(rnd[21:14], rnd[24:22]);
         checkFlags(expectedFlags());
      end

      // Console flag routed through each PI level
      for (int lvl = 1; lvl <= 7; lvl++)
      begin
         loadApr(1'b0, 1'b0, 8'h40, 1'b0, piNumT'(lvl));
         writeFlags(8'h40, '0);
         pis = '0;
         pis.piOn = 1'b1;
         pis.ena[lvl] = 1'b1;
         loadPi(pis);
         checkStatus(mPi);
         tick();
         checkNum(piNumT'(lvl));
      end

      // Mixed request sources against enables and in-progress levels
      for (int n = 0; n < 20; n++)
      begin
         rnd = $random(seed);
         rnd2 = $random(seed);
         loadApr(1'b0, 1'b0, rnd[7:0], rnd[8], rnd[11:9]);
         writeFlags(rnd[19:12], '0);
         extPiReq = rnd[26:20];
         pis.swReq = rnd2[6:0];
         pis.inProg = rnd2[13:7] & rnd2[20:14];
         pis.ena = rnd2[27:21];
         // Mostly on, so the winner logic gets exercised
         pis.piOn = rnd2[28] | rnd2[29];
         loadPi(pis);
         checkStatus(mPi);
         tick();
         checkNum(expectedWinner(extPiReq));
      end

      // Clock enable low freezes every register
      heldNum = expectedWinner(extPiReq);
      clken = 1'b0;
      rnd = $random(seed);
      writeFlags(rnd[7:0], 3'b111);
      loadApr(1'b1, 1'b1, rnd[15:8], 1'b1, rnd[18:16]);
      pis = piStatusT'(rnd[21:0]);
      loadPi(pis);
      extPiReq = rnd[28:22];
      tick();
      checkFlags(expectedFlags());
      checkStatus(mPi);
      checkNum(heldNum);
      clken = 1'b1;
      extPiReq = '0;

      // Hardware pulses between writes are lost
      loadApr(1'b0, 1'b0, 8'hFF, 1'b0, 3'd3);
      writeFlags(8'h00, '0);
      extIntr = 3'b111;
      tick();
      extIntr = '0;
      tick();
      checkFlags(expectedFlags());
      writeFlags(8'h00, '0);
      checkFlags(expectedFlags());
      // Next write with inputs high captures them
      writeFlags(8'h00, 3'b111);
      checkFlags(expectedFlags());

      $display("Errors: %0d", errors);
      if (errors == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== rtl/apr.sv ====
////////////////////////////////////////////////////////////
// Hardware flags latch only at a flags write (set-dominant)
// Interval timer and memory error flags are plain microcode bits
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "ks10_consts.svh"

module apr
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  ks10Pkg::cromWordT  crom,
   input  ks10Pkg::dataWordT  dp,
   input  ks10Pkg::extIntrT   extIntr,
   output ks10Pkg::aprFlagsT  aprFlags,
   output ks10Pkg::piLevelsT  aprIntr
);

   import ks10Pkg::*;

   logic    specLoadApr;
   logic    specAprFlags;
   aprByteT hwSet;
   aprByteT flagReg;
   aprByteT flagEna;
   logic    trapEn;
   logic    pageEn;
   logic    swInt;
   piNumT   intLevel;
   logic    intReq;

   ////////////////////////////////////////////////////////////
   // Special-function decode
   ////////////////////////////////////////////////////////////

   // Write strobes, already qualified by clken
   assign specLoadApr  = clken & crom[`CROM_SPEC_EN] &
      (crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO] == `SPEC_LOADAPR);
   assign specAprFlags = clken & crom[`CROM_SPEC_EN] &
      (crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO] == `SPEC_APRFLAGS);

   ////////////////////////////////////////////////////////////
   // Flag register, dp 24 to 31
   ////////////////////////////////////////////////////////////

   // Hardware sources force their flag on at a write
   // Power fail bit 26, NXM bit 27, console bit 31
   assign hwSet = {2'b00, extIntr.pwr, extIntr.nxm, 3'b000, extIntr.cons};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flagReg <= '0;
      end
      else if (specAprFlags)
      begin
         // Inputs between writes are not remembered
         flagReg <= dp[24:31] | hwSet;
      end
   end

   ////////////////////////////////////////////////////////////
   // Enable register, dp 22 to 35
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEn   <= 1'b0;
         pageEn   <= 1'b0;
         flagEna  <= '0;
         swInt    <= 1'b0;
         intLevel <= '0;
      end
      else if (specLoadApr)
      begin
         trapEn   <= dp[22];
         pageEn   <= dp[23];
         // Per-flag interrupt enables
         flagEna  <= dp[24:31];
         // Software interrupt, bit 32
         swInt    <= dp[32];
         // PI level for APR requests
         intLevel <= dp[33:35];
      end
   end

   ////////////////////////////////////////////////////////////
   // Interrupt request
   ////////////////////////////////////////////////////////////

   // Any enabled flag, or the software bit
   assign intReq = (|(flagReg & flagEna)) | swInt;

   // One-hot request on the stored level, level 0 requests nothing
   always_comb
   begin
      for (int i = 1; i <= 7; i++)
      begin
         aprIntr[i] = intReq && (intLevel == piNumT'(i));
      end
   end

   // Readback word, bits 22 to 35
   always_comb
   begin
      aprFlags.trapEn    = trapEn;
      aprFlags.pageEn    = pageEn;
      aprFlags.soft24    = flagReg[24];
      aprFlags.console25 = flagReg[25];
      aprFlags.pwr       = flagReg[26];
      aprFlags.nxm       = flagReg[27];
      aprFlags.badMem    = flagReg[28];
      aprFlags.corMem    = flagReg[29];
      aprFlags.timer     = flagReg[30];
      aprFlags.cons      = flagReg[31];
      aprFlags.intReq    = intReq;
      // Unused bits always read as ones
      aprFlags.ones      = 3'b111;
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // PI controller relies on at most one APR level
   aprIntrOneHot : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(aprIntr)
   );

   // Readback request bit and PI request stay consistent
   aprIntrNeedsReq : assert property (
      @(posedge clk) disable iff (rst)
      !aprFlags.intReq |-> (aprIntr == '0)
   );

endmodule

// ==== rtl/aprPiTop.sv ====
////////////////////////////////////////////////////////////
// APR device feeding the PI controller
// Both blocks share one microcode word and one data path word
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module aprPiTop
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  ks10Pkg::cromWordT  crom,
   input  ks10Pkg::dataWordT  dp,
   input  ks10Pkg::extIntrT   extIntr,
   input  ks10Pkg::piLevelsT  extPiReq,
   output ks10Pkg::aprFlagsT  aprFlags,
   output ks10Pkg::piStatusT  piStatus,
   output ks10Pkg::piNumT     piReqNum,
   output logic               piReq
);

   import ks10Pkg::*;

   // APR request into the PI merge
   piLevelsT aprIntr;

   // APR status and flags
   apr uApr
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .extIntr  (extIntr),
      .aprFlags (aprFlags),
      .aprIntr  (aprIntr)
   );

   // Priority interrupt system
   piController uPiController
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .aprIntr  (aprIntr),
      .extPiReq (extPiReq),
      .piStatus (piStatus),
      .piReqNum (piReqNum),
      .piReq    (piReq)
   );

endmodule

// ==== rtl/ks10Pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types for the APR device and the PI controller
// Vectors are big-endian; index 0 or 1 is the most significant bit
////////////////////////////////////////////////////////////
`include "ks10_consts.svh"

package ks10Pkg;

   // Microcode word and 36-bit data path word
   typedef logic [0:`CROM_WIDTH-1] cromWordT;
   typedef logic [0:35]            dataWordT;

   // One bit per PI level, level 1 is highest priority
   typedef logic [1:7] piLevelsT;
   // PI level number, 0 means no level
   typedef logic [2:0] piNumT;

   // APR flag byte and its enable mask, dp 24 to 31
   typedef logic [24:31] aprByteT;

   // Hardware interrupt sources into the APR
   typedef struct packed {
      logic pwr;
      logic nxm;
      logic cons;
   } extIntrT;

   // APR readback, maps onto dp 22 to 35
   //   22 trap enable, 23 paging enable
   //   24 to 31 flag byte, 32 interrupt request, 33 to 35 read as ones
   typedef struct packed {
      logic       trapEn;
      logic       pageEn;
      logic       soft24;
      logic       console25;
      logic       pwr;
      logic       nxm;
      logic       badMem;
      logic       corMem;
      logic       timer;
      logic       cons;
      logic       intReq;
      logic [2:0] ones;
   } aprFlagsT;

   // PI register set as loaded by microcode
   typedef struct packed {
      piLevelsT swReq;
      piLevelsT inProg;
      piLevelsT ena;
      logic     piOn;
   } piStatusT;

endpackage

// ==== rtl/ks10_consts.svh ====
////////////////////////////////////////////////////////////
// Bit numbers are big-endian as in the KS10 prints, bit 0 is the MSB
// A _HI bound is the most significant end, so it has the lower index
////////////////////////////////////////////////////////////
`ifndef KS10_CONSTS_SVH
`define KS10_CONSTS_SVH

// Microcode word width
`define CROM_WIDTH        24

// Special-function field enable bit
`define CROM_SPEC_EN      20
// Five-bit special-function selector, crom 15 to 19
`define CROM_SPEC_SEL_HI  15
`define CROM_SPEC_SEL_LO  19

// Special-function selector codes
`define SPEC_LOADAPR      5'h0C
`define SPEC_APRFLAGS     5'h0D
`define SPEC_LOADPI       5'h0A

// PI register fields in a LOADPI data word
`define DP_PI_SWREQ_HI    11
`define DP_PI_SWREQ_LO    17
`define DP_PI_INPROG_HI   21
`define DP_PI_INPROG_LO   27
`define DP_PI_ON          28
`define DP_PI_ENA_HI      29
`define DP_PI_ENA_LO      35

`endif

// ==== rtl/piController.sv ====
////////////////////////////////////////////////////////////
// No acknowledge or dismiss cycle; microcode reloads inProg
// Request number lags the register set by one enabled edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "ks10_consts.svh"

module piController
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  ks10Pkg::cromWordT  crom,
   input  ks10Pkg::dataWordT  dp,
   input  ks10Pkg::piLevelsT  aprIntr,
   input  ks10Pkg::piLevelsT  extPiReq,
   output ks10Pkg::piStatusT  piStatus,
   output ks10Pkg::piNumT     piReqNum,
   output logic               piReq
);

   import ks10Pkg::*;

   logic     specLoadPi;
   piLevelsT candidates;
   piNumT    winner;
   logic     blocked;

   ////////////////////////////////////////////////////////////
   // PI register set
   ////////////////////////////////////////////////////////////

   assign specLoadPi = clken & crom[`CROM_SPEC_EN] &
      (crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO] == `SPEC_LOADPI);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piStatus <= '0;
      end
      else if (specLoadPi)
      begin
         piStatus.swReq  <= dp[`DP_PI_SWREQ_HI:`DP_PI_SWREQ_LO];
         piStatus.inProg <= dp[`DP_PI_INPROG_HI:`DP_PI_INPROG_LO];
         piStatus.piOn   <= dp[`DP_PI_ON];
         piStatus.ena    <= dp[`DP_PI_ENA_HI:`DP_PI_ENA_LO];
      end
   end

   ////////////////////////////////////////////////////////////
   // Priority selection
   ////////////////////////////////////////////////////////////

   // Merge the three sources, then mask by enables and system on
   assign candidates = (piStatus.swReq | aprIntr | extPiReq) &
                       piStatus.ena & {7{piStatus.piOn}};

   // Scan from level 1 down
   // A level in progress blocks itself and everything below
   always_comb
   begin
      winner  = '0;
      blocked = 1'b0;
      for (int i = 1; i <= 7; i++)
      begin
         blocked = blocked | piStatus.inProg[i];
         if (!blocked && candidates[i] && (winner == '0))
         begin
            winner = piNumT'(i);
         end
      end
   end

   // Registered winner, updated every enabled edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piReqNum <= '0;
         piReq    <= 1'b0;
      end
      else if (clken)
      begin
         piReqNum <= winner;
         piReq    <= (winner != '0);
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // System off clears the request on the next enabled edge
   piOffNoReq : assert property (
      @(posedge clk) disable iff (rst)
      (clken && !piStatus.piOn) |=> (piReqNum == '0)
   );

   // Level flag and number agree
   piReqMatchesNum : assert property (
      @(posedge clk) disable iff (rst)
      piReq == (piReqNum != '0)
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the APR/PI testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module aprPiTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VaprPiTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification passed" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
